//--- hw/sparse_sample_pkg.sv
// sparse sample capture, shared definitions
// widths, channel count and the packed beat types used between blocks
`default_nettype none

package sparse_sample_pkg;

  localparam int CHANNELS     = 2;  // input channels, one bank each
  localparam int SAMPLE_WIDTH = 16; // bits per sample
  localparam int TSTAMP_WIDTH = 32; // bits per timestamp
  localparam int OUT_WIDTH    = 32; // output stream word

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // one input beat, all channels side by side
  typedef struct packed {
    sample_t [CHANNELS-1:0] data;
    logic                   valid;
  } sample_bus_t;

  typedef struct packed {
    sample_t high; // go high above this
    sample_t low;  // go low below this
  } threshold_t;

  typedef struct packed {
    threshold_t [CHANNELS-1:0] thresholds;
    logic                      valid;
  } disc_config_t;

  typedef struct packed {
    logic start; // arm a capture
    logic stop;  // end a capture
    logic valid;
  } buffer_config_t;

  // kept samples, qualified per channel
  typedef struct packed {
    sample_t [CHANNELS-1:0] data;
    logic [CHANNELS-1:0]    valid;
  } disc_data_t;

  // {index, clock} per channel
  typedef struct packed {
    logic [CHANNELS-1:0][TSTAMP_WIDTH-1:0] data;
    logic [CHANNELS-1:0]                   valid;
  } disc_tstamp_t;

  typedef struct packed {
    logic [OUT_WIDTH-1:0] data;
    logic                 last;
  } out_beat_t;

endpackage

`default_nettype wire

//--- hw/sample_discriminator.sv
// hysteresis discriminator for all channels
// keeps samples while a channel is high and timestamps each rising transition
`timescale 1ns/100ps
`default_nettype none

module sample_discriminator #(
  parameter int DATA_DEPTH = 1024 // entries per data bank, sizes the sample index
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start_pulse,
  input  sparse_sample_pkg::sample_bus_t  samples_in,
  input  sparse_sample_pkg::disc_config_t disc_config,
  output sparse_sample_pkg::disc_data_t   data_out,
  output sparse_sample_pkg::disc_tstamp_t tstamp_out
);

  import sparse_sample_pkg::*;

  localparam int INDEX_WIDTH = $clog2(DATA_DEPTH);
  localparam int CLOCK_WIDTH = TSTAMP_WIDTH - INDEX_WIDTH; // rest of the timestamp word

  threshold_t [CHANNELS-1:0]                  thresholds;
  logic [CHANNELS-1:0]                        is_high;
  logic [CHANNELS-1:0]                        high_next;
  logic [CHANNELS-1:0][INDEX_WIDTH-1:0]       index;      // kept samples so far, per channel
  logic [CLOCK_WIDTH-1:0]                     clk_count;  // valid beats since start

  // thresholds only change on a config beat
  always_ff @(posedge clk) begin
    if (reset) begin
      thresholds <= '0;
    end else if (disc_config.valid) begin
      thresholds <= disc_config.thresholds;
    end
  end

  // hysteresis: above high sets, below low clears, in between holds
  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      high_next[c] = is_high[c];
      if ($signed(samples_in.data[c]) > $signed(thresholds[c].high)) begin
        high_next[c] = 1'b1;
      end else if ($signed(samples_in.data[c]) < $signed(thresholds[c].low)) begin
        high_next[c] = 1'b0;
      end
    end
  end

  // state and output qualifiers
  always_ff @(posedge clk) begin
    if (reset) begin
      is_high          <= '0;
      index            <= '0;
      clk_count        <= '0;
      data_out.valid   <= '0;
      tstamp_out.valid <= '0;
    end else begin
      data_out.valid   <= '0;
      tstamp_out.valid <= '0;
      if (start_pulse) begin // new capture starts from scratch
        is_high   <= '0;
        index     <= '0;
        clk_count <= '0;
      end else if (samples_in.valid) begin
        clk_count <= clk_count + 1'b1;
        is_high   <= high_next;
        for (int c = 0; c < CHANNELS; c++) begin
          data_out.valid[c]   <= high_next[c];
          tstamp_out.valid[c] <= high_next[c] & ~is_high[c]; // low to high
          if (high_next[c]) begin
            index[c] <= index[c] + 1'b1;
          end
        end
      end
    end
  end

  // payload, qualified by the valids above
  always_ff @(posedge clk) begin
    data_out.data <= samples_in.data;
    for (int c = 0; c < CHANNELS; c++) begin
      tstamp_out.data[c] <= {index[c], clk_count}; // index of this sample, then clock
    end
  end

  // a timestamp comes with its first kept sample, which crossed the high threshold
  generate
    for (genvar c = 0; c < CHANNELS; c++) begin : g_chk
      a_tstamp_crossing: assert property (@(posedge clk) disable iff (reset)
        tstamp_out.valid[c] |-> data_out.valid[c] &&
          ($signed(data_out.data[c]) > $signed($past(thresholds[c].high))));
    end
  endgenerate

endmodule

`default_nettype wire

//--- hw/sample_buffer.sv
// banked capture buffer, one bank per channel
// captures between start and stop/full, then reads every bank out led by its count
`timescale 1ns/100ps
`default_nettype none

module sample_buffer #(
  parameter int WIDTH = 16,  // entry width
  parameter int DEPTH = 1024 // entries per bank
) (
  input  logic                                             clk,
  input  logic                                             reset,
  input  logic                                             start_pulse,
  input  logic                                             stop,
  input  logic                                             stop_aux, // other buffer is full
  input  logic [sparse_sample_pkg::CHANNELS-1:0]            wr_valid,
  input  logic [sparse_sample_pkg::CHANNELS-1:0][WIDTH-1:0] wr_data,
  output logic                                             full,
  output logic [WIDTH-1:0]                                 out_data,
  output logic                                             out_valid,
  output logic                                             out_last,
  input  logic                                             out_ready
);

  import sparse_sample_pkg::*;

  localparam int ADDR_W  = $clog2(DEPTH);
  localparam int COUNT_W = $clog2(DEPTH + 1); // count reaches DEPTH
  localparam int BANK_W  = $clog2(CHANNELS);

  typedef enum logic [1:0] {IDLE, CAPTURE, READOUT} state_t;

  state_t                             state;
  logic [CHANNELS-1:0][COUNT_W-1:0]   count;     // entries held per bank
  logic [CHANNELS-1:0]                bank_full;
  logic [CHANNELS-1:0]                wr_en;
  logic [BANK_W-1:0]                  bank;      // bank being read out
  logic [BANK_W-1:0]                  bank_d;
  logic [COUNT_W-1:0]                 word;      // 0 is the count word, then entries
  logic [COUNT_W-1:0]                 word_d;
  logic [COUNT_W-1:0]                 word_m1;
  logic [ADDR_W-1:0]                  rd_addr;
  logic [WIDTH-1:0]                   rd_data [CHANNELS];
  logic                               load;      // output register takes a new word
  logic                               last_word;

  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      bank_full[c] = (count[c] == COUNT_W'(DEPTH));
      wr_en[c]     = (state == CAPTURE) && wr_valid[c] && !bank_full[c]; // drop when full
    end
  end

  assign full = (state == CAPTURE) && (|bank_full);

  assign load      = (state == READOUT) && (!out_valid || (out_ready && !out_last));
  assign last_word = (bank == BANK_W'(CHANNELS - 1)) && (word == count[bank]);

  // readout pointer, next value also addresses the memories
  always_comb begin
    bank_d = bank;
    word_d = word;
    if (state == CAPTURE) begin
      bank_d = '0;
      word_d = '0;
    end else if (load) begin
      if (word == count[bank]) begin // bank done, move on to next count word
        bank_d = bank + 1'b1;
        word_d = '0;
      end else begin
        word_d = word + 1'b1;
      end
    end
  end

  assign word_m1 = word_d - 1'b1;       // entry n sits at word n+1
  assign rd_addr = word_m1[ADDR_W-1:0];

  generate
    for (genvar c = 0; c < CHANNELS; c++) begin : g_bank
      logic [WIDTH-1:0] mem [DEPTH];
      logic [WIDTH-1:0] rd_q;

      always_ff @(posedge clk) begin
        if (wr_en[c]) begin
          mem[count[c][ADDR_W-1:0]] <= wr_data[c];
        end
        rd_q <= mem[rd_addr]; // ready by the time the pointer gets there
      end

      assign rd_data[c] = rd_q;
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      count     <= '0;
      bank      <= '0;
      word      <= '0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      bank <= bank_d;
      word <= word_d;
      if (start_pulse) begin
        state     <= CAPTURE;
        count     <= '0;
        out_valid <= 1'b0;
        out_last  <= 1'b0;
      end else begin
        case (state)
          CAPTURE: begin
            for (int c = 0; c < CHANNELS; c++) begin
              if (wr_en[c]) begin
                count[c] <= count[c] + 1'b1;
              end
            end
            if (stop || stop_aux || full) begin
              state <= READOUT; // writes in this cycle still land
            end
          end
          READOUT: begin
            if (load) begin
              out_valid <= 1'b1;
              out_last  <= last_word;
            end else if (out_valid && out_ready) begin // final word taken
              out_valid <= 1'b0;
              out_last  <= 1'b0;
              state     <= IDLE;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= (word == '0) ? WIDTH'(count[bank]) : rd_data[bank];
    end
  end

  // a word offered to the reader holds until it is taken
  a_word_held: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready && !start_pulse |=>
      out_valid && $stable(out_data) && $stable(out_last));

endmodule

`default_nettype wire

//--- hw/axis_width_converter.sv
// packs pairs of sample words into one output word
// first word low, second high, a last word alone goes out zero padded
`timescale 1ns/100ps
`default_nettype none

module axis_width_converter (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [sparse_sample_pkg::SAMPLE_WIDTH-1:0] in_data,
  input  logic                                  in_valid,
  input  logic                                  in_last,
  output logic                                  in_ready,
  output sparse_sample_pkg::out_beat_t           out_beat,
  output logic                                  out_valid,
  input  logic                                  out_ready
);

  import sparse_sample_pkg::*;

  logic [SAMPLE_WIDTH-1:0] low_q;    // first half waiting for its partner
  logic                    have_low;
  logic                    in_fire;
  logic                    out_fire;
  logic                    emit;     // this input completes an output word

  assign in_ready = !out_valid || out_ready; // blocked while the output word is stuck
  assign in_fire  = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;
  assign emit     = in_fire && (have_low || in_last);

  always_ff @(posedge clk) begin
    if (reset) begin
      have_low  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (in_fire) begin
        have_low <= !have_low && !in_last;
      end
      if (emit) begin
        out_valid <= 1'b1;
      end else if (out_fire) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire && !have_low) begin
      low_q <= in_data;
    end
    if (emit) begin
      out_beat.data <= have_low ? {in_data, low_q} : {{SAMPLE_WIDTH{1'b0}}, in_data};
      out_beat.last <= in_last;
    end
  end

  // once offered, a word stays offered and unchanged until taken
  a_valid_held: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

`default_nettype wire

//--- hw/sparse_sample_buffer.sv
// sparse sample capture top level
// discriminator feeding timestamp and data buffers, read out as one stream
`timescale 1ns/100ps
`default_nettype none

module sparse_sample_buffer #(
  parameter int DATA_DEPTH   = 1024, // entries per data bank
  parameter int TSTAMP_DEPTH = 64    // entries per timestamp bank
) (
  input  logic                            clk,
  input  logic                            reset,
  input  sparse_sample_pkg::sample_bus_t    samples_in,
  input  sparse_sample_pkg::disc_config_t   disc_config,
  input  sparse_sample_pkg::buffer_config_t buffer_config,
  output sparse_sample_pkg::out_beat_t      out_beat,
  output logic                            out_valid,
  input  logic                            out_ready
);

  import sparse_sample_pkg::*;

  typedef enum logic {SEL_TSTAMP, SEL_DATA} sel_t;

  disc_data_t              disc_data;
  disc_tstamp_t            disc_tstamp;
  logic                    start_q;
  logic                    start_d;
  logic                    start_pulse;
  logic                    stop;
  logic                    data_full;
  logic                    tstamp_full;
  logic [SAMPLE_WIDTH-1:0] data_word;
  logic                    data_valid;
  logic                    data_last;
  logic                    data_ready;
  logic [TSTAMP_WIDTH-1:0] ts_word;
  logic                    ts_valid;
  logic                    ts_last;
  logic                    ts_ready;
  out_beat_t               conv_beat;
  logic                    conv_valid;
  logic                    conv_ready;
  sel_t                    sel;

  // start level from the config beat, edge arms both buffers
  always_ff @(posedge clk) begin
    if (reset) begin
      start_q <= 1'b0;
      start_d <= 1'b0;
    end else begin
      start_d <= start_q;
      if (buffer_config.valid) begin
        start_q <= buffer_config.start;
      end
    end
  end

  assign start_pulse = start_q & ~start_d;
  assign stop        = buffer_config.valid & buffer_config.stop;

  sample_discriminator #(
    .DATA_DEPTH(DATA_DEPTH)
  ) discriminator (
    .clk,
    .reset,
    .start_pulse,
    .samples_in,
    .disc_config,
    .data_out(disc_data),
    .tstamp_out(disc_tstamp)
  );

  sample_buffer #(
    .WIDTH(SAMPLE_WIDTH),
    .DEPTH(DATA_DEPTH)
  ) data_buffer (
    .clk,
    .reset,
    .start_pulse,
    .stop,
    .stop_aux(tstamp_full), // full timestamps end data capture too
    .wr_valid(disc_data.valid),
    .wr_data(disc_data.data),
    .full(data_full),
    .out_data(data_word),
    .out_valid(data_valid),
    .out_last(data_last),
    .out_ready(data_ready)
  );

  sample_buffer #(
    .WIDTH(TSTAMP_WIDTH),
    .DEPTH(TSTAMP_DEPTH)
  ) tstamp_buffer (
    .clk,
    .reset,
    .start_pulse,
    .stop,
    .stop_aux(data_full),
    .wr_valid(disc_tstamp.valid),
    .wr_data(disc_tstamp.data),
    .full(tstamp_full),
    .out_data(ts_word),
    .out_valid(ts_valid),
    .out_last(ts_last),
    .out_ready(ts_ready)
  );

  // only the sample stream needs packing, timestamps are already word sized
  axis_width_converter data_converter (
    .clk,
    .reset,
    .in_data(data_word),
    .in_valid(data_valid),
    .in_last(data_last),
    .in_ready(data_ready),
    .out_beat(conv_beat),
    .out_valid(conv_valid),
    .out_ready(conv_ready)
  );

  // all timestamps first, then all data
  always_ff @(posedge clk) begin
    if (reset) begin
      sel <= SEL_TSTAMP;
    end else if (sel == SEL_TSTAMP && ts_valid && ts_ready && ts_last) begin
      sel <= SEL_DATA;
    end else if (sel == SEL_DATA && conv_valid && conv_ready && conv_beat.last) begin
      sel <= SEL_TSTAMP;
    end
  end

  always_comb begin
    if (sel == SEL_TSTAMP) begin
      out_beat.data = ts_word;
      out_beat.last = 1'b0; // last belongs to the data stream only
      out_valid     = ts_valid;
    end else begin
      out_beat  = conv_beat;
      out_valid = conv_valid;
    end
  end

  assign ts_ready   = (sel == SEL_TSTAMP) && out_ready;
  assign conv_ready = (sel == SEL_DATA) && out_ready;

  // held output across the mux switch as well as within a stream
  a_out_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

`default_nettype wire

//--- test/sparse_sample_model.svh
// reference model of the sparse sample capture block
// replays a recorded input trace into the expected output word list
`ifndef SPARSE_SAMPLE_MODEL_SVH
`define SPARSE_SAMPLE_MODEL_SVH
`default_nettype none

  localparam int INDEX_W = $clog2(DATA_DEPTH);
  localparam int CLOCK_W = TSTAMP_WIDTH - INDEX_W; // low bits of a timestamp

  function automatic void build_expected(input threshold_t [CHANNELS-1:0] th);
    logic [CHANNELS-1:0]     high;
    logic [CHANNELS-1:0]     keep_v;   // beat waiting for its write cycle
    logic [CHANNELS-1:0]     ts_v;
    sample_t [CHANNELS-1:0]  keep;
    logic [TSTAMP_WIDTH-1:0] ts [CHANNELS];
    sample_t                 data_bank [CHANNELS][DATA_DEPTH];
    logic [TSTAMP_WIDTH-1:0] ts_bank [CHANNELS][TSTAMP_DEPTH];
    int                      data_cnt [CHANNELS];
    int                      ts_cnt [CHANNELS];
    int                      index [CHANNELS];
    int                      clock;
    bit                      capturing;
    bit                      stop_now;
    bit                      high_new;
    sample_t                 s;
    logic [SAMPLE_WIDTH-1:0] halves [$]; // data stream before packing
    out_beat_t               beat;
    high      = '0;
    keep_v    = '0;
    ts_v      = '0;
    clock     = 0;
    capturing = 1'b1;
    for (int c = 0; c < CHANNELS; c++) begin
      data_cnt[c] = 0;
      ts_cnt[c]   = 0;
      index[c]    = 0;
    end
    // one pass per cycle, the extra pass lands the final beat
    for (int i = 0; i <= trace_valid.size(); i++) begin
      if (capturing) begin
        stop_now = 1'b0;
        for (int c = 0; c < CHANNELS; c++) begin
          stop_now |= (data_cnt[c] == DATA_DEPTH) || (ts_cnt[c] == TSTAMP_DEPTH);
        end
        for (int c = 0; c < CHANNELS; c++) begin // stop cycle writes still land
          if (keep_v[c] && data_cnt[c] < DATA_DEPTH) begin
            data_bank[c][data_cnt[c]] = keep[c];
            data_cnt[c]++;
          end
          if (ts_v[c] && ts_cnt[c] < TSTAMP_DEPTH) begin
            ts_bank[c][ts_cnt[c]] = ts[c];
            ts_cnt[c]++;
          end
        end
        capturing = !stop_now;
      end
      keep_v = '0;
      ts_v   = '0;
      if (i < trace_valid.size() && trace_valid[i]) begin
        for (int c = 0; c < CHANNELS; c++) begin
          s         = trace_data[i][c];
          high_new  = (s > th[c].high) ? 1'b1 : (s < th[c].low) ? 1'b0 : high[c];
          keep_v[c] = high_new;
          keep[c]   = s;
          ts_v[c]   = high_new && !high[c]; // rising transition
          ts[c]     = {index[c][INDEX_W-1:0], clock[CLOCK_W-1:0]};
          if (high_new) index[c]++;
          high[c] = high_new;
        end
        clock++;
      end
    end
    exp_q.delete();
    beat.last = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin // timestamp banks, last never set
      beat.data = OUT_WIDTH'(ts_cnt[c]);
      exp_q.push_back(beat);
      for (int k = 0; k < ts_cnt[c]; k++) begin
        beat.data = ts_bank[c][k];
        exp_q.push_back(beat);
      end
    end
    for (int c = 0; c < CHANNELS; c++) begin
      halves.push_back(SAMPLE_WIDTH'(data_cnt[c]));
      for (int k = 0; k < data_cnt[c]; k++) begin
        halves.push_back(data_bank[c][k]);
      end
    end
    if (halves.size() % 2 == 1) halves.push_back('0); // odd total padded
    for (int k = 0; k < halves.size(); k += 2) begin
      beat.data = {halves[k + 1], halves[k]}; // low half first
      beat.last = (k + 2 == halves.size());
      exp_q.push_back(beat);
    end
  endfunction

`default_nettype wire
`endif

//--- test/sparse_sample_buffer_tb.sv
// testbench for the sparse sample capture block
// random and directed captures checked word by word against a reference model
`timescale 1ns/100ps
`default_nettype none

module sparse_sample_buffer_tb;

  import sparse_sample_pkg::*;

  localparam int DATA_DEPTH   = 64;
  localparam int TSTAMP_DEPTH = 8;
  localparam int NUM_TESTS    = 5;
  localparam int SETUP_CYCLES = 30; // config, start gap, stop and tail
  localparam int MAX_WORDS    = 2 * (TSTAMP_DEPTH + 1) + DATA_DEPTH + 1;
  localparam int SLOWDOWN     = 8;  // cycles per word allowed under random ready

  logic           clk;
  logic           reset;
  sample_bus_t    samples_in;
  disc_config_t   disc_config;
  buffer_config_t buffer_config;
  out_beat_t      out_beat;
  logic           out_valid;
  logic           out_ready;

  threshold_t [CHANNELS-1:0] test_th;
  bit                        trace_valid [$];
  sample_t [CHANNELS-1:0]    trace_data [$];
  out_beat_t                 exp_q [$];
  int exp_base     = 0; // rx_total when the current test began
  int rx_total     = 0;
  int last_total   = 0;
  int beat_errors  = 0;
  int count_errors = 0;
  int tests_run    = 0;
  int ready_mode   = 0; // 0 random, 1 with long stalls

  sparse_sample_buffer #(
    .DATA_DEPTH(DATA_DEPTH),
    .TSTAMP_DEPTH(TSTAMP_DEPTH)
  ) dut (
    .clk,
    .reset,
    .samples_in,
    .disc_config,
    .buffer_config,
    .out_beat,
    .out_valid,
    .out_ready
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int trace_length(input int kind);
    case (kind)
      0: return 60;
      1: return 80;
      2: return 40;
      3: return 90;
      default: return 50;
    endcase
  endfunction

  function automatic threshold_t make_threshold(input int high, input int low);
    threshold_t t;
    t.high = sample_t'(high);
    t.low  = sample_t'(low);
    return t;
  endfunction

  function automatic int random_walk(input int value, input int lo, input int hi);
    int next;
    next = value + int'($urandom_range(120)) - 60;
    if (next < lo) next = lo;
    if (next > hi) next = hi;
    return next;
  endfunction

  function automatic void make_trace(input int kind);
    int                     w0;
    int                     w1;
    int                     valid_pct;
    sample_t [CHANNELS-1:0] beat_d;
    trace_valid.delete();
    trace_data.delete();
    w0        = 0;
    w1        = 0;
    valid_pct = 100;
    case (kind)
      0: begin
        test_th[0] = make_threshold(200, -200);
        test_th[1] = make_threshold(1500, 900);
        w1         = 1200;
        valid_pct  = 80;
      end
      1: begin
        test_th[0] = make_threshold(50, -50);
        test_th[1] = make_threshold(-400, -800); // negative window on channel 1
        w1         = -600;
        valid_pct  = 90;
      end
      2: begin // channel 0 rises every 4 beats, overruns a timestamp bank
        test_th[0] = make_threshold(100, -100);
        test_th[1] = make_threshold(1000, 0);
      end
      3: begin // channel 1 never drops and overruns its data bank
        test_th[0] = make_threshold(-100, -300);
        test_th[1] = make_threshold(1000, 500);
      end
      default: begin
        test_th[0] = make_threshold(300, 0);
        test_th[1] = make_threshold(2500, 2000);
        w0         = 150;
        w1         = 2200;
        valid_pct  = 60;
      end
    endcase
    for (int i = 0; i < trace_length(kind); i++) begin
      w0        = random_walk(w0, -1000, 1000);
      w1        = random_walk(w1, -3000, 3000);
      beat_d[0] = sample_t'(w0);
      beat_d[1] = sample_t'(w1);
      if (kind == 2) begin
        beat_d[0] = ((i / 2) % 2 == 0) ? 16'sd500 : -16'sd500;
        beat_d[1] = -16'sd50;
      end else if (kind == 3) begin
        beat_d[1] = 16'sd3000;
      end
      trace_data.push_back(beat_d);
      trace_valid.push_back(int'($urandom_range(99)) < valid_pct);
    end
  endfunction

  task automatic check_beat(input out_beat_t got, input out_beat_t want, input int pos);
    if (got !== want) begin
      $display("Error at time %0t: word %0d is %h last %b, expected %h last %b",
               $time, pos, got.data, got.last, want.data, want.last);
      beat_errors++;
    end
  endtask

  task automatic check_count(input int got, input int want, input string name);
    if (got != want) begin
      $display("Error at time %0t: %s gave %0d words, expected %0d", $time, name, got, want);
      count_errors++;
    end
  endtask

  // takes every accepted word and compares it in order
  always @(posedge clk) begin : collect
    int pos;
    if (!reset && out_valid && out_ready) begin
      pos = rx_total - exp_base;
      if (pos < exp_q.size()) begin
        check_beat(out_beat, exp_q[pos], pos);
      end else begin
        $display("Output word %0d arrived beyond the %0d expected words", pos, exp_q.size());
        beat_errors++;
      end
      rx_total++;
      if (out_beat.last) last_total++;
    end
  end

  initial begin : ready_gen
    int stall;
    stall     = 0;
    out_ready = 1'b0;
    forever begin
      @(posedge clk);
      if (stall == 0 && ready_mode == 1 && $urandom_range(15) == 0) begin
        stall = int'($urandom_range(30, 5)); // long low stretch
      end
      if (stall > 0) begin
        stall--;
        out_ready <= 1'b0;
      end else begin
        out_ready <= (ready_mode == 1) ? ($urandom_range(1) == 1) : ($urandom_range(3) != 0);
      end
    end
  end

  task automatic run_test(input string name, input int kind, input int mode);
    int err_base;
    int last_base;
    int words;
    make_trace(kind);
    build_expected(test_th); // ready before a full stop can start the readout
    err_base   = beat_errors + count_errors;
    last_base  = last_total;
    exp_base   = rx_total;
    ready_mode = mode;
    @(posedge clk);
    disc_config <= '{thresholds: test_th, valid: 1'b1};
    @(posedge clk);
    disc_config.valid <= 1'b0;
    buffer_config     <= '{start: 1'b1, stop: 1'b0, valid: 1'b1};
    @(posedge clk);
    buffer_config.valid <= 1'b0;
    repeat (5) @(posedge clk); // start pulse clears the counters first
    for (int i = 0; i < trace_valid.size(); i++) begin
      samples_in <= '{data: trace_data[i], valid: trace_valid[i]};
      @(posedge clk);
    end
    samples_in.valid <= 1'b0;
    repeat (4) @(posedge clk);
    buffer_config <= '{start: 1'b0, stop: 1'b1, valid: 1'b1}; // also drops the start level
    @(posedge clk);
    buffer_config.valid <= 1'b0;
    while (last_total == last_base) @(posedge clk);
    repeat (12) @(posedge clk); // catch any stray extra words
    words = rx_total - exp_base;
    check_count(words, exp_q.size(), name);
    tests_run++;
    $display("test %-12s %3d words, %0d errors", name, words,
             beat_errors + count_errors - err_base);
  endtask

  initial begin : watchdog
    int budget;
    budget = 0;
    for (int k = 0; k < NUM_TESTS; k++) begin
      budget += trace_length(k) + SETUP_CYCLES + MAX_WORDS * SLOWDOWN;
    end
    repeat (4 * budget) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", 4 * budget);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    int total;
    void'($urandom(85));
    reset         = 1'b1;
    samples_in    = '0;
    disc_config   = '0;
    buffer_config = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);
    run_test("hysteresis", 0, 0);
    run_test("backpressure", 1, 1);
    run_test("tstamp_full", 2, 0);
    run_test("data_full", 3, 1);
    run_test("restart", 4, 0);  // fresh indices and clock after a full readout
    total = beat_errors + count_errors;
    $display("%0d tests, %0d words, %0d errors", tests_run, rx_total, total);
    if (total == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

`include "sparse_sample_model.svh"

endmodule

`default_nettype wire

//--- sparse_sample_buffer.f
+incdir+test
hw/sparse_sample_pkg.sv
hw/sample_discriminator.sv
hw/sample_buffer.sv
hw/axis_width_converter.sv
hw/sparse_sample_buffer.sv
test/sparse_sample_buffer_tb.sv

//--- Makefile
# Verilator build and run for the sparse sample capture block

VERILATOR ?= verilator
TOP       ?= sparse_sample_buffer_tb
FILELIST  ?= sparse_sample_buffer.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard test/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
